/* verilog.f */
+incdir+verilog
verilog/hps_link_pkg.sv
verilog/uio_frame.sv
verilog/host_regs.sv
verilog/ps2_key_decoder.sv
verilog/file_loader.sv
verilog/hps_link.sv
sim/hps_link_checker.sv
sim/tb_hps_link.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_hps_link
FILELIST  := verilog.f
FLAGS     := --binary --timing --timescale 1ns/1ps -Mdir obj_dir
LOG       := sim.log

SOURCES   := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_hps_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module tb_hps_link;
	import hps_link_pkg::*;

	localparam logic [2:0] SEL_JOY0   = 3'd0;
	localparam logic [2:0] SEL_JOY1   = 3'd1;
	localparam logic [2:0] SEL_STATUS = 3'd2;
	localparam logic [2:0] SEL_KEY    = 3'd3;
	localparam logic [2:0] SEL_DOUT   = 3'd4;
	localparam logic [2:0] SEL_DL     = 3'd5;
	localparam logic [2:0] SEL_INDEX  = 3'd6;

	logic                       clk_sys;
	logic                       reset;
	logic                       io_strobe;
	logic                       io_enable;
	logic                       fp_enable;
	logic [`HPS_WORD_W-1:0]     io_din;
	logic [`STATUS_W-1:0]       status_in;
	logic                       status_set;
	wire  [`HPS_WORD_W-1:0]     io_dout;
	wire  [`JOY_W-1:0]          joystick_0;
	wire  [`JOY_W-1:0]          joystick_1;
	wire  [`STATUS_W-1:0]       status;
	wire  [10:0]                ps2_key;
	wire                        ioctl_download;
	wire  [15:0]                ioctl_index;
	wire                        ioctl_wr;
	wire  [`IOCTL_ADDR_W-1:0]   ioctl_addr;
	wire  [`IOCTL_DATA_W-1:0]   ioctl_dout;

	// expectations handed to the checker
	logic                       chk_en;
	logic [2:0]                 chk_sel;
	logic [63:0]                chk_exp;
	logic [`IOCTL_ADDR_W-1:0]   wr_exp_addr;
	logic [`IOCTL_DATA_W-1:0]   wr_exp_data;
	logic                       report;
	wire  [31:0]                check_count;
	wire  [31:0]                error_count;
	wire  [31:0]                wr_count;

	int unsigned                seed;
	logic [31:0]                errs_before;
	logic                       timed_out;
	logic [10:0]                key_model;
	logic [3:0]                 set_count;
	logic [63:0]                captured;
	logic [31:0]                v0;
	logic [31:0]                v1;
	logic [63:0]                sv;

	hps_link u_hps_link (
		.clk_sys, .reset, .io_strobe, .io_enable, .fp_enable, .io_din, .io_dout,
		.status_in, .status_set, .joystick_0, .joystick_1, .status, .ps2_key,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout
	);

	hps_link_checker u_checker (
		.clk_sys, .reset, .joystick_0, .joystick_1, .status, .ps2_key, .io_dout,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.chk_en, .chk_sel, .chk_exp, .wr_exp_addr, .wr_exp_data, .report,
		.check_count, .error_count, .wr_count
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	// seq holds the bytes oldest first with the newest in [7:0]
	function automatic logic [10:0] ref_key(input logic [10:0] prev, input logic [31:0] seq,
		input int n);
		logic [7:0] second;
		logic [7:0] third;
		logic       pressed;
		logic       extended;
		second   = (n > 1) ? seq[15:8] : 8'h00;
		third    = (n > 2) ? seq[23:16] : 8'h00;
		pressed  = (second != 8'hF0);
		extended = pressed ? (second == 8'hE0) : (third == 8'hE0);
		return {~prev[10], pressed, extended, seq[7:0]};
	endfunction

	// word 0 answers the command and words 1..4 carry the capture
	function automatic logic [15:0] ref_status_resp(input logic [63:0] cap,
		input logic [3:0] n, input int idx);
		if (idx == 0)
			return {8'h00, `STATUS_TAG, n};
		return cap[16*(idx-1) +: 16];
	endfunction

	function automatic logic [26:0] ref_write_addr(input logic [26:0] start,
		input logic [26:0] k);
		return start + k;
	endfunction

	////////////////////////////////////////////////////////////
	// host bus tasks return 1 ns after a rising edge
	////////////////////////////////////////////////////////////
	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic expect_out(input logic [2:0] sel, input logic [63:0] exp);
		chk_sel = sel;
		chk_exp = exp;
		chk_en  = 1'b1;
		idle(1);
		chk_en  = 1'b0;
	endtask

	task automatic send_word(input logic [15:0] w);
		io_din    = w;
		io_strobe = 1'b1;
		idle(1);
		io_strobe = 1'b0;
		idle(2);
	endtask

	// response sampled in the second idle cycle
	task automatic read_word(input logic [15:0] w, input logic [15:0] exp);
		io_din    = w;
		io_strobe = 1'b1;
		idle(1);
		io_strobe = 1'b0;
		idle(1);
		expect_out(SEL_DOUT, {48'b0, exp});
	endtask

	task automatic begin_frame(input logic file_frame);
		if (file_frame)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		idle(1);
	endtask

	task automatic end_frame;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		idle(4);
	endtask

	task automatic uio_write(input uio_cmd_e c, input logic [63:0] v, input int words);
		int i;
		begin_frame(1'b0);
		send_word({8'h00, c});
		for (i = 0; i < words; i++)
			send_word(v[16*i +: 16]);
		end_frame();
	endtask

	task automatic status_pulse(input logic [63:0] v);
		status_in  = v;
		status_set = 1'b1;
		idle(1);
		// only the rising edge captures
		status_in  = ~v;
		idle(1);
		status_set = 1'b0;
		idle(1);
	endtask

	task automatic status_readback;
		int i;
		begin_frame(1'b0);
		read_word({8'h00, UIO_STATUS_GET}, ref_status_resp(captured, set_count, 0));
		for (i = 1; i <= `STATUS_WORDS; i++)
			read_word(16'h0000, ref_status_resp(captured, set_count, i));
		end_frame();
		// frame end clears the response
		expect_out(SEL_DOUT, 64'd0);
	endtask

	// skip_pos below zero sends no marked word
	task automatic key_frame(input logic [31:0] seq, input int n, input int skip_pos);
		int         i;
		logic [7:0] hi;
		begin_frame(1'b0);
		send_word({8'h00, UIO_KEYBOARD});
		for (i = 0; i < n; i++) begin
			hi = (i == skip_pos) ? `PS2_SKIP_MARK : 8'h00;
			send_word({hi, seq[8*(n-1-i) +: 8]});
		end
		end_frame();
		if (skip_pos < 0)
			key_model = ref_key(key_model, seq, n);
		expect_out(SEL_KEY, {53'b0, key_model});
	endtask

	task automatic wait_write(input logic [31:0] target);
		int t;
		t = 0;
		while (wr_count != target && t < 20) begin
			idle(1);
			t++;
		end
		if (wr_count != target) begin
			timed_out = 1'b1;
			$display("timeout: ioctl write count stayed at %0d, expected %0d",
				wr_count, target);
		end
	endtask

	task automatic file_download(input int n);
		logic [31:0] r;
		logic [26:0] start;
		logic [15:0] index;
		logic [15:0] w;
		logic [31:0] base;
		int          i;
		r     = $urandom;
		start = r[26:0];
		r     = $urandom;
		index = r[15:0];
		begin_frame(1'b1);
		send_word({8'h00, FIO_FILE_INDEX});
		send_word(index);
		end_frame();
		expect_out(SEL_INDEX, {48'b0, index});
		begin_frame(1'b1);
		send_word({8'h00, FIO_FILE_TX});
		send_word(16'h00FF);
		send_word(start[15:0]);
		send_word({5'b0, start[26:16]});
		end_frame();
		expect_out(SEL_DL, 64'd1);
		base = wr_count;
		begin_frame(1'b1);
		send_word({8'h00, FIO_FILE_TX_DAT});
		for (i = 0; i < n; i++) begin
			r           = $urandom;
			w           = r[15:0];
			wr_exp_addr = ref_write_addr(start, 27'(i));
			wr_exp_data = w[7:0];
			send_word(w);
			wait_write(base + i + 1);
			if (timed_out)
				break;
		end
		end_frame();
		expect_out(SEL_DL, 64'd1);
		begin_frame(1'b1);
		send_word({8'h00, FIO_FILE_TX});
		send_word(16'h0000);
		end_frame();
		expect_out(SEL_DL, 64'd0);
		// no write pulse beyond the data words
		wait_write(base + n);
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d errors", name, error_count - errs_before);
		errs_before = error_count;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial begin
		seed        = $urandom(54669);
		io_strobe   = 1'b0;
		io_enable   = 1'b0;
		fp_enable   = 1'b0;
		io_din      = '0;
		status_in   = '0;
		status_set  = 1'b0;
		chk_en      = 1'b0;
		chk_sel     = SEL_JOY0;
		chk_exp     = '0;
		wr_exp_addr = '0;
		wr_exp_data = '0;
		report      = 1'b0;
		errs_before = '0;
		timed_out   = 1'b0;
		key_model   = '0;
		set_count   = '0;
		captured    = '0;
		reset       = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		idle(2);

		v0 = $urandom;
		v1 = $urandom;
		uio_write(UIO_JOY0, {32'b0, v0}, 2);
		uio_write(UIO_JOY1, {32'b0, v1}, 2);
		expect_out(SEL_JOY0, {32'b0, v0});
		expect_out(SEL_JOY1, {32'b0, v1});
		finish_test("joystick writes");

		sv = {$urandom, $urandom};
		uio_write(UIO_STATUS, sv, `STATUS_WORDS);
		expect_out(SEL_STATUS, sv);
		finish_test("status write");

		// counter and capture follow each rising edge
		repeat (3) begin
			captured  = {$urandom, $urandom};
			status_pulse(captured);
			set_count = set_count + 4'd1;
		end
		status_readback();
		repeat (2) begin
			captured  = {$urandom, $urandom};
			status_pulse(captured);
			set_count = set_count + 4'd1;
		end
		status_readback();
		finish_test("status readback");

		key_frame(32'h0000001C, 1, -1);
		key_frame(32'h0000F01C, 2, -1);
		key_frame(32'h0000E075, 2, -1);
		key_frame(32'h00E0F075, 3, -1);
		key_frame(32'h001C2233, 3, 1);
		key_frame(32'h00E0F06B, 3, -1);
		finish_test("keyboard events");

		file_download(8);
		finish_test("file download");

		report = 1'b1;
		idle(1);
		report = 1'b0;
		if (error_count == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/hps_link_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module hps_link_checker (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire [`JOY_W-1:0]           joystick_0,
	input  wire [`JOY_W-1:0]           joystick_1,
	input  wire [`STATUS_W-1:0]        status,
	input  wire [10:0]                 ps2_key,
	input  wire [`HPS_WORD_W-1:0]      io_dout,
	input  wire                        ioctl_download,
	input  wire [15:0]                 ioctl_index,
	input  wire                        ioctl_wr,
	input  wire [`IOCTL_ADDR_W-1:0]    ioctl_addr,
	input  wire [`IOCTL_DATA_W-1:0]    ioctl_dout,
	input  wire                        chk_en,
	input  wire [2:0]                  chk_sel,
	input  wire [63:0]                 chk_exp,
	input  wire [`IOCTL_ADDR_W-1:0]    wr_exp_addr,
	input  wire [`IOCTL_DATA_W-1:0]    wr_exp_data,
	input  wire                        report,
	output logic [31:0]                check_count,
	output logic [31:0]                error_count,
	output logic [31:0]                wr_count
);

	localparam logic [2:0] SEL_JOY0   = 3'd0;
	localparam logic [2:0] SEL_JOY1   = 3'd1;
	localparam logic [2:0] SEL_STATUS = 3'd2;
	localparam logic [2:0] SEL_KEY    = 3'd3;
	localparam logic [2:0] SEL_DOUT   = 3'd4;
	localparam logic [2:0] SEL_DL     = 3'd5;
	localparam logic [2:0] SEL_INDEX  = 3'd6;

	logic [63:0] got;
	int          new_checks;
	int          new_errors;

	function automatic string sel_name(input logic [2:0] sel);
		case (sel)
			SEL_JOY0:   return "joystick_0";
			SEL_JOY1:   return "joystick_1";
			SEL_STATUS: return "status";
			SEL_KEY:    return "ps2_key";
			SEL_DOUT:   return "io_dout";
			SEL_DL:     return "ioctl_download";
			SEL_INDEX:  return "ioctl_index";
			default:    return "unknown output";
		endcase
	endfunction

	// output under test, zero extended
	always_comb begin
		case (chk_sel)
			SEL_JOY0:   got = {32'b0, joystick_0};
			SEL_JOY1:   got = {32'b0, joystick_1};
			SEL_STATUS: got = status;
			SEL_KEY:    got = {53'b0, ps2_key};
			SEL_DOUT:   got = {48'b0, io_dout};
			SEL_DL:     got = {63'b0, ioctl_download};
			SEL_INDEX:  got = {48'b0, ioctl_index};
			default:    got = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// compare on request, and on every write pulse
	////////////////////////////////////////////////////////////
	always @(posedge clk_sys) begin
		new_checks = 0;
		new_errors = 0;
		if (reset) begin
			check_count <= '0;
			error_count <= '0;
			wr_count    <= '0;
		end else begin
			if (chk_en) begin
				new_checks = new_checks + 1;
				if (got !== chk_exp) begin
					new_errors = new_errors + 1;
					$display("[ERROR] %0t: %s is %h, expected %h",
						$time, sel_name(chk_sel), got, chk_exp);
				end
			end
			if (ioctl_wr) begin
				new_checks = new_checks + 1;
				wr_count <= wr_count + 1;
				if (ioctl_addr !== wr_exp_addr || ioctl_dout !== wr_exp_data) begin
					new_errors = new_errors + 1;
					$display("[ERROR] %0t: ioctl write %h/%h, expected %h/%h",
						$time, ioctl_addr, ioctl_dout, wr_exp_addr, wr_exp_data);
				end
			end
			check_count <= check_count + new_checks;
			error_count <= error_count + new_errors;
			if (report)
				$display("checks: %0d, errors: %0d, writes: %0d",
					check_count, error_count, wr_count);
		end
	end

endmodule

`default_nettype wire

/* verilog/hps_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module hps_link (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       io_strobe,
	input  wire                       io_enable,
	input  wire                       fp_enable,
	input  wire [`HPS_WORD_W-1:0]     io_din,
	output logic [`HPS_WORD_W-1:0]    io_dout,
	input  wire [`STATUS_W-1:0]       status_in,
	input  wire                       status_set,
	output logic [`JOY_W-1:0]         joystick_0,
	output logic [`JOY_W-1:0]         joystick_1,
	output logic [`STATUS_W-1:0]      status,
	output logic [10:0]               ps2_key,
	output logic                      ioctl_download,
	output logic [15:0]               ioctl_index,
	output logic                      ioctl_wr,
	output logic [`IOCTL_ADDR_W-1:0]  ioctl_addr,
	output logic [`IOCTL_DATA_W-1:0]  ioctl_dout
);
	import hps_link_pkg::*;

	// user-I/O frame, shared by register and keyboard blocks
	wire                    cmd_strobe;
	wire                    data_strobe;
	wire                    frame_end;
	uio_cmd_e               cmd;
	wire [`WORD_IDX_W-1:0]  word_idx;
	wire [`HPS_WORD_W-1:0]  din;

	uio_frame u_uio_frame (
		.clk_sys, .reset, .io_strobe, .io_enable, .io_din,
		.cmd_strobe, .data_strobe, .frame_end, .cmd, .word_idx, .din
	);

	host_regs u_host_regs (
		.clk_sys, .reset, .cmd_strobe, .data_strobe, .frame_end, .cmd, .word_idx, .din,
		.status_in, .status_set, .joystick_0, .joystick_1, .status, .io_dout
	);

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys, .reset, .cmd_strobe, .data_strobe, .frame_end, .cmd, .din,
		.ps2_key
	);

	// file path decodes the raw bus itself
	file_loader u_file_loader (
		.clk_sys, .reset, .io_strobe, .fp_enable, .io_din,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout
	);

endmodule

`default_nettype wire

/* verilog/file_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module file_loader (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       io_strobe,
	input  wire                       fp_enable,
	input  wire [`HPS_WORD_W-1:0]     io_din,
	output logic                      ioctl_download,
	output logic [15:0]               ioctl_index,
	output logic                      ioctl_wr,
	output logic [`IOCTL_ADDR_W-1:0]  ioctl_addr,
	output logic [`IOCTL_DATA_W-1:0]  ioctl_dout
);
	import hps_link_pkg::*;

	fio_cmd_e                fcmd;
	logic                    has_cmd;
	logic [1:0]              cnt;
	logic [`IOCTL_ADDR_W-1:0] addr;
	logic                    wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			has_cmd        <= 1'b0;
			cnt            <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
		end else begin
			// write pulse trails the data by one cycle
			ioctl_wr <= wr;
			wr       <= 1'b0;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					fcmd    <= fio_cmd_e'(io_din[7:0]);
					has_cmd <= 1'b1;
					cnt     <= '0;
				end else begin
					case (fcmd)
						FIO_FILE_INDEX: ioctl_index <= io_din;

						FIO_FILE_TX: begin
							if (~&cnt)
								cnt <= cnt + 1'b1;
							case (cnt)
								2'd0: begin
									// nonzero starts, zero ends
									if (io_din[7:0] != 8'h00) begin
										addr           <= '0;
										ioctl_download <= 1'b1;
									end else begin
										if (ioctl_download)
											ioctl_addr <= addr;
										ioctl_download <= 1'b0;
									end
								end
								2'd1: addr[`HPS_WORD_W-1:0] <= io_din;
								2'd2: addr[`IOCTL_ADDR_W-1:`HPS_WORD_W] <=
									io_din[`IOCTL_ADDR_W-`HPS_WORD_W-1:0];
								default: ;
							endcase
						end

						FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din[`IOCTL_DATA_W-1:0];
								wr         <= 1'b1;
								addr       <= addr + 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/ps2_key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module ps2_key_decoder (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           cmd_strobe,
	input  wire                           data_strobe,
	input  wire                           frame_end,
	input  wire hps_link_pkg::uio_cmd_e   cmd,
	input  wire        [`HPS_WORD_W-1:0]  din,
	output logic       [10:0]             ps2_key
);
	import hps_link_pkg::*;

	logic [31:0] key_raw;
	logic        kbd_frame;
	logic        skip;
	logic        pressed;
	logic        extended;

	// newest byte in [7:0], F0 break code just before it
	assign pressed  = (key_raw[15:8] != 8'hF0);
	assign extended = pressed ? (key_raw[15:8] == 8'hE0) : (key_raw[23:16] == 8'hE0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kbd_frame <= 1'b0;
			skip      <= 1'b0;
			ps2_key   <= '0;
		end else begin
			if (cmd_strobe) begin
				kbd_frame <= (cmd == UIO_KEYBOARD);
				skip      <= 1'b0;
			end else if (data_strobe && kbd_frame) begin
				// marked word poisons the rest of the frame
				if (din[15:8] == `PS2_SKIP_MARK)
					skip <= 1'b1;
			end

			if (frame_end) begin
				kbd_frame <= 1'b0;
				if (kbd_frame && !skip)
					ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
			end
		end
	end

	// raw byte history
	always_ff @(posedge clk_sys) begin
		if (cmd_strobe && cmd == UIO_KEYBOARD)
			key_raw <= '0;
		else if (data_strobe && kbd_frame && !skip && din[15:8] != `PS2_SKIP_MARK)
			key_raw <= {key_raw[23:0], din[7:0]};
	end

endmodule

`default_nettype wire

/* verilog/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module host_regs (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           cmd_strobe,
	input  wire                           data_strobe,
	input  wire                           frame_end,
	input  wire hps_link_pkg::uio_cmd_e   cmd,
	input  wire        [`WORD_IDX_W-1:0]  word_idx,
	input  wire        [`HPS_WORD_W-1:0]  din,
	input  wire        [`STATUS_W-1:0]    status_in,
	input  wire                           status_set,
	output logic       [`JOY_W-1:0]       joystick_0,
	output logic       [`JOY_W-1:0]       joystick_1,
	output logic       [`STATUS_W-1:0]    status,
	output logic       [`HPS_WORD_W-1:0]  io_dout
);
	import hps_link_pkg::*;

	logic                 status_set_q;
	logic [3:0]           stflg;
	logic [`STATUS_W-1:0] status_req;
	logic [1:0]           part;
	logic                 part_ok;

	// status words 1..4 map to 16-bit slices from the bottom
	assign part    = word_idx[1:0] - 2'd1;
	assign part_ok = (word_idx != '0) && (word_idx <= `STATUS_WORDS);

	////////////////////////////////////////////////////////////
	// status-set requests from the core
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_q <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q)
				stflg <= stflg + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q)
			status_req <= status_in;
	end

	////////////////////////////////////////////////////////////
	// host writes and read response
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			io_dout    <= '0;
		end else begin
			if (frame_end || cmd_strobe || data_strobe)
				io_dout <= '0;

			// counter tag answered on the command word itself
			if (cmd_strobe && cmd == UIO_STATUS_GET)
				io_dout <= {{(`HPS_WORD_W-8){1'b0}}, `STATUS_TAG, stflg};

			if (data_strobe) begin
				case (cmd)
					UIO_JOY0: begin
						if (word_idx == 1)
							joystick_0[`HPS_WORD_W-1:0] <= din;
						else if (word_idx == 2)
							joystick_0[`JOY_W-1:`HPS_WORD_W] <= din;
					end
					UIO_JOY1: begin
						if (word_idx == 1)
							joystick_1[`HPS_WORD_W-1:0] <= din;
						else if (word_idx == 2)
							joystick_1[`JOY_W-1:`HPS_WORD_W] <= din;
					end
					UIO_STATUS: if (part_ok) status[{part, 4'b0000} +: `HPS_WORD_W] <= din;
					UIO_STATUS_GET: if (part_ok) io_dout <= status_req[{part, 4'b0000} +: `HPS_WORD_W];
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/uio_frame.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hps_link_settings.svh"

module uio_frame (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           io_strobe,
	input  wire                           io_enable,
	input  wire        [`HPS_WORD_W-1:0]  io_din,
	output logic                          cmd_strobe,
	output logic                          data_strobe,
	output logic                          frame_end,
	output hps_link_pkg::uio_cmd_e        cmd,
	output logic       [`WORD_IDX_W-1:0]  word_idx,
	output logic       [`HPS_WORD_W-1:0]  din
);
	import hps_link_pkg::*;

	logic enable_q;
	logic has_cmd;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			enable_q    <= 1'b0;
			has_cmd     <= 1'b0;
			cmd         <= UIO_NONE;
			word_idx    <= '0;
			cmd_strobe  <= 1'b0;
			data_strobe <= 1'b0;
			frame_end   <= 1'b0;
		end else begin
			enable_q    <= io_enable;
			frame_end   <= enable_q & ~io_enable;
			cmd_strobe  <= 1'b0;
			data_strobe <= 1'b0;

			// end of frame, drop the command
			if (enable_q && !io_enable) begin
				has_cmd  <= 1'b0;
				cmd      <= UIO_NONE;
				word_idx <= '0;
			end else if (io_enable && io_strobe) begin
				if (!has_cmd) begin
					has_cmd    <= 1'b1;
					cmd        <= uio_cmd_e'(io_din[7:0]);
					cmd_strobe <= 1'b1;
				end else begin
					// index sticks at all ones on long frames
					if (~&word_idx)
						word_idx <= word_idx + 1'b1;
					data_strobe <= 1'b1;
				end
			end
		end
	end

	// word follows the strobes by one cycle
	always_ff @(posedge clk_sys) begin
		if (io_strobe)
			din <= io_din;
	end

endmodule

`default_nettype wire

/* verilog/hps_link_pkg.sv */
`default_nettype none

package hps_link_pkg;

	////////////////////////////////////////////////////////////
	// user-I/O command bytes, low byte of the first word
	////////////////////////////////////////////////////////////
	typedef enum logic [7:0] {
		UIO_NONE       = 8'h00,
		UIO_JOY0       = 8'h02,
		UIO_JOY1       = 8'h03,
		UIO_KEYBOARD   = 8'h05,
		UIO_STATUS     = 8'h1E,
		UIO_STATUS_GET = 8'h29
	} uio_cmd_e;

	////////////////////////////////////////////////////////////
	// file-I/O command bytes
	////////////////////////////////////////////////////////////
	typedef enum logic [7:0] {
		FIO_FILE_TX     = 8'h53,
		FIO_FILE_TX_DAT = 8'h54,
		FIO_FILE_INDEX  = 8'h55
	} fio_cmd_e;

endpackage

`default_nettype wire

/* verilog/hps_link_settings.svh */
`ifndef HPS_LINK_SETTINGS_SVH
`define HPS_LINK_SETTINGS_SVH

// host bus word
`define HPS_WORD_W     16

// user-I/O register widths
`define JOY_W          32
`define STATUS_W       64
`define STATUS_WORDS   4
`define WORD_IDX_W     6
`define STATUS_TAG     4'hA
`define PS2_SKIP_MARK  8'hFF

// download port
`define IOCTL_ADDR_W   27
`define IOCTL_DATA_W   8

`endif
